/* Makefile */
# Verilator build for the PMP checker testbench

VERILATOR ?= verilator
TOP       ?= pmp_unit_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
+incdir+verilog
verilog/pmp_pkg.sv
verilog/pmp_cfg_regs.sv
verilog/pmp_check.sv
verilog/pmp_fetch_port.sv
verilog/pmp_data_port.sv
verilog/pmp_unit_top.sv
verification/pmp_unit_sva.sv
verification/pmp_unit_tb.sv

/* verification/pmp_unit_sva.sv */
//--------------------------------------------------------------------
// PMP checker assertions
// APB handshake, data-port latency and reset state
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pmp_params.svh"

module pmp_unit_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input pmp_pkg::apb_req_t   apb_req_i,
  input pmp_pkg::apb_rsp_t   apb_rsp_o,
  input pmp_pkg::lsu_req_t   lsu_req_i,
  input pmp_pkg::lsu_rsp_t   lsu_rsp_o
);

  import pmp_pkg::*;

  //------------------------------------------------------------------
  // APB
  //------------------------------------------------------------------
  // pready only while setup has moved on to access
  a_pready_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    apb_rsp_o.pready |-> (apb_req_i.psel && apb_req_i.penable &&
                          $past(apb_req_i.psel && !apb_req_i.penable)))
    else $error("pready outside the APB access phase");

  //------------------------------------------------------------------
  // Data port
  //------------------------------------------------------------------
  // Exactly one register stage
  a_lsu_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_rsp_o.valid == $past(lsu_req_i.req))
    else $error("lsu valid does not follow req by one cycle");

  // Nothing comes out while held in reset
  a_lsu_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !lsu_rsp_o.valid)
    else $error("lsu valid high during reset");

endmodule

`default_nettype wire

/* verification/pmp_unit_tb.sv */
//--------------------------------------------------------------------
// PMP checker testbench
// APB setup, fetch and load/store checks against a reference model
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pmp_params.svh"

module pmp_unit_tb;

  import pmp_pkg::*;

  logic       clk_i;
  logic       rst_ni;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  priv_lvl_e  priv_lvl;
  priv_lvl_e  ld_st_priv;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  lsu_req_t   lsu_req;
  lsu_rsp_t   lsu_rsp;

  // Shadow copy of the registers, kept by the lock rules
  logic [7:0]  shadow_cfg  [`PMP_NR_ENTRIES];
  logic [29:0] shadow_addr [`PMP_NR_ENTRIES];
  logic [31:0] rng_state;

  pmp_unit_top dut0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .apb_req_i        (apb_req),
    .apb_rsp_o        (apb_rsp),
    .priv_lvl_i       (priv_lvl),
    .ld_st_priv_lvl_i (ld_st_priv),
    .fetch_req_i      (fetch_req),
    .fetch_rsp_o      (fetch_rsp),
    .lsu_req_i        (lsu_req),
    .lsu_rsp_o        (lsu_rsp)
  );

  bind pmp_unit_top pmp_unit_sva u_sva (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .lsu_req_i (lsu_req_i),
    .lsu_rsp_o (lsu_rsp_o)
  );

  always #4 clk_i = ~clk_i;

  //------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic expect_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (exp === act) else begin
      $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timed out waiting for %s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  // Region match of one entry, from the address-mode rules
  function automatic logic entry_hit(input int i, input logic [31:0] a);
    logic [31:0] lo;
    logic [31:0] word;
    int          t;
    word = {2'b00, shadow_addr[i]};
    lo   = (i == 0) ? 32'h0 : {shadow_addr[i-1], 2'b00};
    t    = 0;
    case (shadow_cfg[i][4:3])
      2'b01: return (a >= lo) && (a < {shadow_addr[i], 2'b00});
      2'b10: return a[31:2] == shadow_addr[i];
      2'b11: begin
        while (t < 30 && word[t]) t++;
        return ({2'b00, a[31:2]} >> (t + 1)) == (word >> (t + 1));
      end
      default: return 1'b0;
    endcase
  endfunction

  // Bit index 0 read, 1 write, 2 execute
  function automatic logic ref_allow(input logic [31:0] a, input int kind, input logic m_mode);
    for (int i = 0; i < `PMP_NR_ENTRIES; i++) begin
      if (entry_hit(i, a)) return shadow_cfg[i][kind] || (m_mode && !shadow_cfg[i][7]);
    end
    return m_mode;
  endfunction

  //------------------------------------------------------------------
  // APB
  //------------------------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [7:0] a, input logic [31:0] wd,
                          output logic [31:0] rd, output logic err);
    int n;
    n = 0;
    @(posedge clk_i);
    #1;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: wd};
    @(posedge clk_i);
    #1;
    apb_req.penable = 1'b1;
    #1;
    while (!apb_rsp.pready) begin
      if (n >= 16) timeout_abort("APB pready");
      @(posedge clk_i);
      #2;
      n++;
    end
    rd  = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(posedge clk_i);
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic cfg_write(input int w, input logic [31:0] d);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, `PMP_CFG_BASE + 8'(4 * w), d, rd, err);
    expect_eq("pslverr", 0, err);
    for (int k = 0; k < 4; k++) begin
      if (!shadow_cfg[4*w+k][7]) shadow_cfg[4*w+k] = d[8*k +: 8] & 8'h9F;
    end
  endtask

  task automatic addr_write(input int i, input logic [31:0] d);
    logic [31:0] rd;
    logic        err;
    logic        tor_lock;
    apb_xfer(1'b1, `PMP_ADDR_BASE + 8'(4 * i), d, rd, err);
    expect_eq("pslverr", 0, err);
    tor_lock = (i < `PMP_NR_ENTRIES - 1) && shadow_cfg[i+1][7] && (shadow_cfg[i+1][4:3] == 2'b01);
    if (!shadow_cfg[i][7] && !tor_lock) shadow_addr[i] = d[29:0];
  endtask

  task automatic check_regs;
    logic [31:0] rd;
    logic        err;
    for (int w = 0; w < `PMP_NR_ENTRIES / 4; w++) begin
      apb_xfer(1'b0, `PMP_CFG_BASE + 8'(4 * w), 0, rd, err);
      expect_eq("prdata cfg", {shadow_cfg[4*w+3], shadow_cfg[4*w+2],
                               shadow_cfg[4*w+1], shadow_cfg[4*w]}, rd);
    end
    for (int i = 0; i < `PMP_NR_ENTRIES; i++) begin
      apb_xfer(1'b0, `PMP_ADDR_BASE + 8'(4 * i), 0, rd, err);
      expect_eq("prdata pmpaddr", {2'b00, shadow_addr[i]}, rd);
    end
  endtask

  //------------------------------------------------------------------
  // Fetch and data ports
  //------------------------------------------------------------------
  task automatic check_fetch(input priv_lvl_e p, input logic [31:0] a);
    logic ok;
    @(posedge clk_i);
    #1;
    priv_lvl  = p;
    fetch_req = '{fetch_req: 1'b1, fetch_vaddr: a};
    #2;
    ok = ref_allow(a, 2, p == PRIV_M);
    expect_eq("fetch_valid", 1, fetch_rsp.fetch_valid);
    expect_eq("fetch_paddr", a, fetch_rsp.fetch_paddr);
    expect_eq("fetch_exception.valid", !ok, fetch_rsp.fetch_exception.valid);
    if (!ok) begin
      expect_eq("fetch_exception.cause", 1, fetch_rsp.fetch_exception.cause);
      expect_eq("fetch_exception.tval", a, fetch_rsp.fetch_exception.tval);
    end
  endtask

  task automatic drive_lsu(input logic r, input logic [31:0] a, input logic st, input exception_t m);
    lsu_req = '{req: r, vaddr: a, is_store: st, misaligned_ex: m};
  endtask

  // Response one cycle after a request, held privilege in ld_st_priv
  task automatic check_lsu(input logic r, input logic [31:0] a, input logic st, input exception_t m);
    exception_t exp_ex;
    exp_ex = '0;
    if (r && m.valid) exp_ex = m;
    else if (r && !ref_allow(a, st ? 1 : 0, ld_st_priv == PRIV_M)) begin
      exp_ex.valid = 1'b1;
      exp_ex.cause = st ? 32'd7 : 32'd5;
      exp_ex.tval  = a;
    end
    expect_eq("lsu_rsp.valid", r, lsu_rsp.valid);
    expect_eq("lsu_rsp.exception.valid", exp_ex.valid, lsu_rsp.exception.valid);
    if (r) begin
      expect_eq("lsu_rsp.paddr", a, lsu_rsp.paddr);
      expect_eq("lsu_rsp.exception", exp_ex, lsu_rsp.exception);
    end
  endtask

  task automatic data_access(input priv_lvl_e p, input logic r, input logic [31:0] a,
                             input logic st, input exception_t m);
    @(posedge clk_i);
    #1;
    ld_st_priv = p;
    drive_lsu(r, a, st, m);
    @(posedge clk_i);
    #1;
    drive_lsu(1'b0, 0, 1'b0, '0);
    #1;
    check_lsu(r, a, st, m);
  endtask

  //------------------------------------------------------------------
  // Sequence
  //------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic        err;
    exception_t  mis;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    apb_req = '0;
    priv_lvl = PRIV_M;
    ld_st_priv = PRIV_M;
    fetch_req = '0;
    lsu_req = '0;
    rng_state = 32'h5074_3e1a;
    for (int i = 0; i < `PMP_NR_ENTRIES; i++) begin
      shadow_cfg[i]  = '0;
      shadow_addr[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    expect_eq("lsu_rsp.valid", 0, lsu_rsp.valid);

    // Reset state, everything open to machine mode
    check_regs();
    check_fetch(PRIV_M, 32'h1234_5678);
    data_access(PRIV_M, 1'b1, 32'h0000_0100, 1'b1, '0);

    // Unmapped addresses
    apb_xfer(1'b1, 8'h40, 32'hFFFF_FFFF, rd, err);
    expect_eq("pslverr", 1, err);
    apb_xfer(1'b0, 8'h30, 0, rd, err);
    expect_eq("pslverr", 1, err);

    // NAPOT 4K rx, NA4 rw, TOR rx, overlapping NAPOT 64K with no rights
    addr_write(0, 32'h0400_01FF);
    addr_write(1, 32'h0800_0000);
    addr_write(2, 32'h0C00_0000);
    addr_write(3, 32'h0400_1FFF);
    cfg_write(0, 32'h180D_137D);
    check_regs();

    check_fetch(PRIV_U, 32'h1000_0010);
    check_fetch(PRIV_U, 32'h1000_2000);
    check_fetch(PRIV_U, 32'h2000_0000);
    check_fetch(PRIV_U, 32'h2800_0000);
    check_fetch(PRIV_U, 32'h4000_0000);
    for (int n = 0; n < 24; n++) begin
      rng_state = lcg_next(rng_state);
      check_fetch(PRIV_U, rng_state & 32'h3000_3FFC);
    end

    // Loads and stores in both modes
    data_access(PRIV_U, 1'b1, 32'h2000_0000, 1'b1, '0);
    data_access(PRIV_U, 1'b1, 32'h1000_0010, 1'b0, '0);
    data_access(PRIV_U, 1'b1, 32'h1000_0010, 1'b1, '0);
    data_access(PRIV_U, 1'b1, 32'h4000_0000, 1'b0, '0);
    data_access(PRIV_M, 1'b1, 32'h1000_2000, 1'b1, '0);

    // Back-to-back requests
    @(posedge clk_i);
    #1;
    ld_st_priv = PRIV_U;
    drive_lsu(1'b1, 32'h2000_0000, 1'b1, '0);
    @(posedge clk_i);
    #1;
    drive_lsu(1'b1, 32'h4000_0000, 1'b0, '0);
    #1;
    check_lsu(1'b1, 32'h2000_0000, 1'b1, '0);
    @(posedge clk_i);
    #1;
    drive_lsu(1'b0, 0, 1'b0, '0);
    #1;
    check_lsu(1'b1, 32'h4000_0000, 1'b0, '0);

    // Misaligned wins over PMP, and is muted without a request
    mis = '{valid: 1'b1, cause: 32'd6, tval: 32'h4000_0001};
    data_access(PRIV_U, 1'b1, 32'h4000_0001, 1'b1, mis);
    data_access(PRIV_U, 1'b0, 32'h4000_0001, 1'b1, mis);

    // Locked TOR entry 5 with read only
    addr_write(4, 32'h1400_0000);
    addr_write(5, 32'h1600_0000);
    cfg_write(1, 32'h0000_8900);
    check_fetch(PRIV_M, 32'h5000_0000);
    data_access(PRIV_M, 1'b1, 32'h5000_0000, 1'b0, '0);
    data_access(PRIV_M, 1'b1, 32'h5000_0000, 1'b1, '0);
    addr_write(5, 32'h1700_0000);
    addr_write(4, 32'h1500_0000);
    cfg_write(1, 32'h0D0D_0D0D);
    check_regs();
    check_fetch(PRIV_M, 32'h5000_0004);
    check_fetch(PRIV_U, 32'h5000_0004);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/pmp_cfg_regs.sv */
//--------------------------------------------------------------------
// PMP configuration registers
// APB slave holding pmpcfg and pmpaddr with the lock write rules
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pmp_params.svh"

module pmp_cfg_regs (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  pmp_pkg::apb_req_t                             apb_req_i,
  output pmp_pkg::apb_rsp_t                             apb_rsp_o,
  output pmp_pkg::pmpcfg_t [`PMP_NR_ENTRIES-1:0]        pmpcfg_o,
  output logic [`PMP_NR_ENTRIES-1:0][`PMP_PLEN-3:0]     pmpaddr_o
);

  import pmp_pkg::*;

  localparam int unsigned NrEntries = `PMP_NR_ENTRIES;
  localparam int unsigned Aw        = `PMP_APB_AW;
  // Byte span of each register window
  localparam int unsigned CfgSpan   = NrEntries;
  localparam int unsigned AddrSpan  = 4 * NrEntries;

  pmpcfg_t [NrEntries-1:0]                  pmpcfg_q;
  logic    [NrEntries-1:0][`PMP_PLEN-3:0]   pmpaddr_q;

  logic                access;
  logic                wr_en;
  logic [Aw-1:0]       cfg_off;
  logic [Aw-1:0]       addr_off;
  logic                cfg_hit;
  logic                addr_hit;
  logic [Aw-3:0]       cfg_word;
  logic [Aw-3:0]       addr_idx;
  pmpcfg_t [3:0]       wr_cfg;
  logic [NrEntries-1:0] cfg_we;
  logic [NrEntries-1:0] addr_we;
  logic [31:0]         rdata;

  //------------------------------------------------------------------
  // Address decode
  //------------------------------------------------------------------
  // No wait states, so every access phase completes
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  // Offsets below a base wrap around and miss the span check
  assign cfg_off  = apb_req_i.paddr - `PMP_CFG_BASE;
  assign addr_off = apb_req_i.paddr - `PMP_ADDR_BASE;
  assign cfg_hit  = (cfg_off < CfgSpan) && (apb_req_i.paddr[1:0] == 2'b00);
  assign addr_hit = (addr_off < AddrSpan) && (apb_req_i.paddr[1:0] == 2'b00);
  assign cfg_word = cfg_off[Aw-1:2];
  assign addr_idx = addr_off[Aw-1:2];

  // Incoming cfg bytes, reserved bits forced to zero
  always_comb begin
    for (int unsigned k = 0; k < 4; k++) begin
      wr_cfg[k]          = pmpcfg_t'(apb_req_i.pwdata[8*k +: 8]);
      wr_cfg[k].reserved = 2'b00;
    end
  end

  //------------------------------------------------------------------
  // Write enables with lock rules
  //------------------------------------------------------------------
  for (genvar i = 0; i < NrEntries; i++) begin : g_we
    logic tor_lock;
    // Locked TOR entry above also freezes this address
    if (i < NrEntries - 1) begin : g_upper
      assign tor_lock = pmpcfg_q[i+1].locked && (pmpcfg_q[i+1].addr_mode == TOR);
    end else begin : g_last
      assign tor_lock = 1'b0;
    end
    assign cfg_we[i]  = wr_en && cfg_hit && (cfg_word == (i / 4)) && !pmpcfg_q[i].locked;
    assign addr_we[i] = wr_en && addr_hit && (addr_idx == i) &&
                        !pmpcfg_q[i].locked && !tor_lock;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pmpcfg_q  <= '0;
      pmpaddr_q <= '0;
    end else begin
      for (int unsigned e = 0; e < NrEntries; e++) begin
        if (cfg_we[e]) begin
          pmpcfg_q[e] <= wr_cfg[e % 4];
        end
        if (addr_we[e]) begin
          pmpaddr_q[e] <= apb_req_i.pwdata[`PMP_PLEN-3:0];
        end
      end
    end
  end

  //------------------------------------------------------------------
  // Read data
  //------------------------------------------------------------------
  always_comb begin
    rdata = '0;
    for (int unsigned e = 0; e < NrEntries; e++) begin
      if (cfg_hit && (cfg_word == (e / 4))) begin
        rdata[8*(e%4) +: 8] = pmpcfg_q[e];
      end
      if (addr_hit && (addr_idx == e)) begin
        rdata = 32'(pmpaddr_q[e]);
      end
    end
  end

  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.prdata  = access ? rdata : '0;
  assign apb_rsp_o.pslverr = access && !cfg_hit && !addr_hit;

  assign pmpcfg_o  = pmpcfg_q;
  assign pmpaddr_o = pmpaddr_q;

endmodule

`default_nettype wire

/* verilog/pmp_check.sv */
//--------------------------------------------------------------------
// PMP permission check
// Priority-ordered match over all entries for a single access
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pmp_params.svh"

module pmp_check (
  input  logic [`PMP_PLEN-1:0]                          addr_i,
  input  pmp_pkg::access_e                              access_i,
  input  pmp_pkg::priv_lvl_e                            priv_i,
  input  pmp_pkg::pmpcfg_t [`PMP_NR_ENTRIES-1:0]        pmpcfg_i,
  input  logic [`PMP_NR_ENTRIES-1:0][`PMP_PLEN-3:0]     pmpaddr_i,
  output logic                                          allow_o
);

  import pmp_pkg::*;

  localparam int unsigned NrEntries = `PMP_NR_ENTRIES;
  localparam int unsigned Plen      = `PMP_PLEN;

  logic [NrEntries-1:0] match;
  logic [NrEntries-1:0] perm;

  //------------------------------------------------------------------
  // Per-entry address match
  //------------------------------------------------------------------
  for (genvar i = 0; i < NrEntries; i++) begin : g_entry
    logic [Plen-1:0] tor_lo;
    logic [Plen-1:0] tor_hi;
    logic [Plen-3:0] napot_mask;
    logic            hit;
    logic            bit_ok;

    // Entry 0 starts its TOR range at zero
    if (i == 0) begin : g_first
      assign tor_lo = '0;
    end else begin : g_next
      assign tor_lo = {pmpaddr_i[i-1], 2'b00};
    end
    assign tor_hi = {pmpaddr_i[i], 2'b00};

    // Trailing ones plus the first zero are don't-care bits
    assign napot_mask = ~(pmpaddr_i[i] ^ (pmpaddr_i[i] + 1'b1));

    always_comb begin
      case (pmpcfg_i[i].addr_mode)
        TOR:     hit = (addr_i >= tor_lo) && (addr_i < tor_hi);
        NA4:     hit = (addr_i[Plen-1:2] == pmpaddr_i[i]);
        NAPOT:   hit = ((addr_i[Plen-1:2] ^ pmpaddr_i[i]) & napot_mask) == '0;
        default: hit = 1'b0;
      endcase
    end

    // Permission bit for the requested access kind
    always_comb begin
      case (access_i)
        ACCESS_READ:  bit_ok = pmpcfg_i[i].r;
        ACCESS_WRITE: bit_ok = pmpcfg_i[i].w;
        ACCESS_EXEC:  bit_ok = pmpcfg_i[i].x;
        default:      bit_ok = 1'b0;
      endcase
    end

    assign match[i] = hit;
    // Unlocked entries do not restrict machine mode
    assign perm[i]  = bit_ok || ((priv_i == PRIV_M) && !pmpcfg_i[i].locked);
  end

  //------------------------------------------------------------------
  // Priority resolution
  //------------------------------------------------------------------
  // Walk from the top so the lowest matching entry is applied last
  always_comb begin
    // No match at all, only machine mode passes
    allow_o = (priv_i == PRIV_M);
    for (int i = NrEntries - 1; i >= 0; i--) begin
      if (match[i]) begin
        allow_o = perm[i];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/pmp_data_port.sv */
//--------------------------------------------------------------------
// PMP data port
// One register stage for load/store with misaligned and PMP faults
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pmp_params.svh"

module pmp_data_port (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  pmp_pkg::lsu_req_t         lsu_req_i,
  output pmp_pkg::lsu_rsp_t         lsu_rsp_o,
  input  logic                      allow_i,
  output logic [`PMP_PLEN-1:0]      chk_addr_o,
  output pmp_pkg::access_e          chk_access_o
);

  import pmp_pkg::*;

  // Control state
  logic                 req_q;
  logic                 mis_valid_q;
  // Payload
  logic [`PMP_PLEN-1:0] vaddr_q;
  logic                 is_store_q;
  exception_t           mis_ex_q;

  //------------------------------------------------------------------
  // Request stage
  //------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      mis_valid_q <= 1'b0;
    end else begin
      req_q       <= lsu_req_i.req;
      // Without a request the misaligned flag is stale
      mis_valid_q <= lsu_req_i.misaligned_ex.valid & lsu_req_i.req;
    end
  end

  // New request taken every cycle, no stall
  always_ff @(posedge clk_i) begin
    vaddr_q    <= lsu_req_i.vaddr;
    is_store_q <= lsu_req_i.is_store;
    mis_ex_q   <= lsu_req_i.misaligned_ex;
  end

  // Checker works on the registered copy
  assign chk_addr_o   = vaddr_q;
  assign chk_access_o = is_store_q ? ACCESS_WRITE : ACCESS_READ;

  //------------------------------------------------------------------
  // Response
  //------------------------------------------------------------------
  always_comb begin
    lsu_rsp_o.valid     = req_q;
    lsu_rsp_o.paddr     = vaddr_q;
    lsu_rsp_o.exception = '0;

    // Misaligned from the LSU wins over a PMP fault
    if (mis_valid_q) begin
      lsu_rsp_o.exception       = mis_ex_q;
      lsu_rsp_o.exception.valid = 1'b1;
    end else if (req_q && !allow_i) begin
      lsu_rsp_o.exception.valid = 1'b1;
      lsu_rsp_o.exception.cause = is_store_q ? CAUSE_ST_ACCESS_FAULT
                                             : CAUSE_LD_ACCESS_FAULT;
      lsu_rsp_o.exception.tval  = `PMP_XLEN'(vaddr_q);
    end
  end

endmodule

`default_nettype wire

/* verilog/pmp_fetch_port.sv */
//--------------------------------------------------------------------
// PMP fetch port
// Same-cycle fetch response with instruction access fault
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pmp_params.svh"

module pmp_fetch_port (
  input  pmp_pkg::fetch_req_t       fetch_req_i,
  output pmp_pkg::fetch_rsp_t       fetch_rsp_o,
  input  logic                      allow_i,
  output logic [`PMP_PLEN-1:0]      chk_addr_o
);

  import pmp_pkg::*;

  // Bare mode, virtual and physical address are the same
  assign chk_addr_o = fetch_req_i.fetch_vaddr;

  always_comb begin
    fetch_rsp_o.fetch_valid     = fetch_req_i.fetch_req;
    fetch_rsp_o.fetch_paddr     = fetch_req_i.fetch_vaddr;
    fetch_rsp_o.fetch_exception = '0;

    // Denied fetch raises the fault in the same cycle
    if (fetch_req_i.fetch_req && !allow_i) begin
      fetch_rsp_o.fetch_exception.valid = 1'b1;
      fetch_rsp_o.fetch_exception.cause = CAUSE_INSTR_ACCESS_FAULT;
      fetch_rsp_o.fetch_exception.tval  = `PMP_XLEN'(fetch_req_i.fetch_vaddr);
    end
  end

endmodule

`default_nettype wire

/* verilog/pmp_params.svh */
//--------------------------------------------------------------------
// PMP checker parameters
// Address and data widths, entry count and the APB register map
//--------------------------------------------------------------------
`ifndef PMP_PARAMS_SVH
`define PMP_PARAMS_SVH

// Physical address width, no translation in front of it
`define PMP_PLEN 32
// Width of the exception tval field
`define PMP_XLEN 32
// Number of PMP entries, a multiple of four
`define PMP_NR_ENTRIES 8
// APB address width
`define PMP_APB_AW 8
// Two cfg words, four entries per word
`define PMP_CFG_BASE 8'h00
// pmpaddr word array, entry i at base + 4*i
`define PMP_ADDR_BASE 8'h10

`endif

/* verilog/pmp_pkg.sv */
//--------------------------------------------------------------------
// PMP checker types
// Privilege, access, PMP config, exception and port records
//--------------------------------------------------------------------
`default_nettype none

`include "pmp_params.svh"

package pmp_pkg;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [1:0] {
    ACCESS_READ  = 2'b01,
    ACCESS_WRITE = 2'b10,
    ACCESS_EXEC  = 2'b11
  } access_e;

  // Address matching mode of one entry
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pmp_mode_e;

  // Layout as in the privileged spec, MSB first
  typedef struct packed {
    logic      locked;
    logic [1:0] reserved;
    pmp_mode_e addr_mode;
    logic      x;
    logic      w;
    logic      r;
  } pmpcfg_t;

  // Exception causes seen at the two ports
  localparam logic [31:0] CAUSE_INSTR_ACCESS_FAULT = 32'd1;
  localparam logic [31:0] CAUSE_LD_MISALIGNED      = 32'd4;
  localparam logic [31:0] CAUSE_LD_ACCESS_FAULT    = 32'd5;
  localparam logic [31:0] CAUSE_ST_MISALIGNED      = 32'd6;
  localparam logic [31:0] CAUSE_ST_ACCESS_FAULT    = 32'd7;

  typedef struct packed {
    logic                 valid;
    logic [31:0]          cause;
    logic [`PMP_XLEN-1:0] tval;
  } exception_t;

  // Fetch port
  typedef struct packed {
    logic                 fetch_req;
    logic [`PMP_PLEN-1:0] fetch_vaddr;
  } fetch_req_t;

  typedef struct packed {
    logic                 fetch_valid;
    logic [`PMP_PLEN-1:0] fetch_paddr;
    exception_t           fetch_exception;
  } fetch_rsp_t;

  // Load/store port
  typedef struct packed {
    logic                 req;
    logic [`PMP_PLEN-1:0] vaddr;
    logic                 is_store;
    exception_t           misaligned_ex;
  } lsu_req_t;

  typedef struct packed {
    logic                 valid;
    logic [`PMP_PLEN-1:0] paddr;
    exception_t           exception;
  } lsu_rsp_t;

  // APB slave side
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`PMP_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/pmp_unit_top.sv */
//--------------------------------------------------------------------
// PMP checker top level
// APB config registers, fetch and data checkers with their ports
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pmp_params.svh"

module pmp_unit_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Configuration bus
  input  pmp_pkg::apb_req_t     apb_req_i,
  output pmp_pkg::apb_rsp_t     apb_rsp_o,
  // Privilege for fetch and for load/store
  input  pmp_pkg::priv_lvl_e    priv_lvl_i,
  input  pmp_pkg::priv_lvl_e    ld_st_priv_lvl_i,
  // Fetch port
  input  pmp_pkg::fetch_req_t   fetch_req_i,
  output pmp_pkg::fetch_rsp_t   fetch_rsp_o,
  // Load/store port
  input  pmp_pkg::lsu_req_t     lsu_req_i,
  output pmp_pkg::lsu_rsp_t     lsu_rsp_o
);

  import pmp_pkg::*;

  pmpcfg_t [`PMP_NR_ENTRIES-1:0]                pmpcfg;
  logic    [`PMP_NR_ENTRIES-1:0][`PMP_PLEN-3:0] pmpaddr;

  logic [`PMP_PLEN-1:0] fetch_chk_addr;
  logic                 fetch_allow;
  logic [`PMP_PLEN-1:0] data_chk_addr;
  access_e              data_chk_access;
  logic                 data_allow;

  //------------------------------------------------------------------
  // Configuration
  //------------------------------------------------------------------
  pmp_cfg_regs u_cfg_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .pmpcfg_o  (pmpcfg),
    .pmpaddr_o (pmpaddr)
  );

  //------------------------------------------------------------------
  // Fetch path
  //------------------------------------------------------------------
  // Every fetch is checked as execute
  pmp_check u_check_fetch (
    .addr_i    (fetch_chk_addr),
    .access_i  (ACCESS_EXEC),
    .priv_i    (priv_lvl_i),
    .pmpcfg_i  (pmpcfg),
    .pmpaddr_i (pmpaddr),
    .allow_o   (fetch_allow)
  );

  pmp_fetch_port u_fetch_port (
    .fetch_req_i (fetch_req_i),
    .fetch_rsp_o (fetch_rsp_o),
    .allow_i     (fetch_allow),
    .chk_addr_o  (fetch_chk_addr)
  );

  //------------------------------------------------------------------
  // Data path
  //------------------------------------------------------------------
  pmp_check u_check_data (
    .addr_i    (data_chk_addr),
    .access_i  (data_chk_access),
    .priv_i    (ld_st_priv_lvl_i),
    .pmpcfg_i  (pmpcfg),
    .pmpaddr_i (pmpaddr),
    .allow_o   (data_allow)
  );

  pmp_data_port u_data_port (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lsu_req_i    (lsu_req_i),
    .lsu_rsp_o    (lsu_rsp_o),
    .allow_i      (data_allow),
    .chk_addr_o   (data_chk_addr),
    .chk_access_o (data_chk_access)
  );

endmodule

`default_nettype wire
